// ==== dv/corr_sva.sv ====
// Concurrent assertions on the Wishbone handshake and the integration window.
`timescale 1ns/1ps

module corr_sva (
	input logic pllclk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic integrating,
	input logic irq
);

	ack_single: assert property (@(posedge pllclk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles in a row");

	ack_after_strobe: assert property (@(posedge pllclk) disable iff (!rst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without a strobe in the previous cycle");

	// irq marks the cycle the window closes.
	irq_after_window: assert property (@(posedge pllclk) disable iff (!rst_n)
		irq |-> $past(integrating))
		else $error("irq pulsed without integrating in the previous cycle");

	idle_after_reset: assert property (@(posedge pllclk)
		!rst_n |=> !integrating)
		else $error("integrating was high in the cycle after reset");

endmodule

bind corr_top corr_sva sva0 (
	.pllclk      (pllclk),
	.rst_n       (rst_n),
	.wb_cyc      (wb_cyc),
	.wb_stb      (wb_stb),
	.wb_ack      (wb_ack),
	.integrating (integrating),
	.irq         (irq)
);

// ==== dv/corr_tb.sv ====
// Directed correlator tests with a counting reference model, timeout and result line.
`timescale 1ns/1ps

module corr_tb import corr_pkg::*; ();

	localparam int sched_len = 1900; // Pulse schedule, well inside a 2000-cycle window.
	localparam int lead_cycles = 20;
	localparam int count_window = 2000;
	localparam int max_cycles = 20000; // About twice the five windows plus bus traffic.

	logic pllclk;
	logic rst_n;
	logic [num_inputs-1:0] line_in;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [wb_adr_width-1:0] wb_adr;
	logic [wb_dat_width-1:0] wb_dat_i;
	logic [wb_dat_width-1:0] wb_dat_o;
	logic wb_ack;
	logic irq;

	logic [num_inputs-1:0] sched [sched_len]; // Rising edges per offset cycle.
	int exp_auto [num_inputs];
	int exp_cross [num_cross];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int irq_count = 0;
	int exp_frames = 0;
	int windows_run = 0;
	integer seed;

	tb_clkgen clkgen0 (.pllclk(pllclk), .rst_n(rst_n));

	corr_top dut0 (
		.pllclk   (pllclk),
		.rst_n    (rst_n),
		.line_in  (line_in),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.irq      (irq)
	);

	always @(negedge pllclk) begin
		if (irq)
			irq_count++;
	end

	always @(posedge pllclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic wb_access(input logic we, input logic [wb_adr_width-1:0] adr,
		input logic [wb_dat_width-1:0] data, output logic [wb_dat_width-1:0] rdata);
		@(posedge pllclk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_i <= data;
		do @(negedge pllclk); while (!wb_ack);
		rdata = wb_dat_o; // Valid while ack is high.
		@(posedge pllclk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic [wb_adr_width-1:0] adr, input logic [wb_dat_width-1:0] data);
		logic [wb_dat_width-1:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [wb_adr_width-1:0] adr, output logic [wb_dat_width-1:0] data);
		wb_access(1'b0, adr, '0, data);
	endtask

	task automatic read_expect(input logic [wb_adr_width-1:0] adr,
		input logic [wb_dat_width-1:0] exp, input string name);
		logic [wb_dat_width-1:0] got;
		wb_read(adr, got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at 0x%02h: got 0x%08h, expected 0x%08h", name, adr, got, exp);
		end
	endtask

	task automatic expect_counts();
		for (int c = 0; c < num_inputs; c++)
			read_expect(wb_adr_width'(reg_auto_base + c), 32'(exp_auto[c]),
				$sformatf("auto_count[%0d]", c));
		for (int k = 0; k < num_cross; k++)
			read_expect(wb_adr_width'(reg_cross_base + k), 32'(exp_cross[k]),
				$sformatf("cross_count[%0d]", k));
	endtask

	task automatic clear_sched();
		for (int t = 0; t < sched_len; t++)
			sched[t] = '0;
	endtask

	task automatic add_pulses(input int ch, input int first, input int step, input int n);
		for (int k = 0; k < n; k++)
			sched[first + k * step][ch] = 1'b1;
	endtask

	// Reference model: lag +1 is j one cycle after i, lag -1 is j one cycle before.
	task automatic compute_expected();
		int pair;
		for (int c = 0; c < num_inputs; c++)
			exp_auto[c] = 0;
		for (int k = 0; k < num_cross; k++)
			exp_cross[k] = 0;
		for (int t = 0; t < sched_len; t++) begin
			pair = 0;
			for (int c = 0; c < num_inputs; c++)
				if (sched[t][c])
					exp_auto[c]++;
			for (int i = 0; i < num_inputs - 1; i++) begin
				for (int j = i + 1; j < num_inputs; j++) begin
					if (sched[t][i] && sched[t][j])
						exp_cross[pair * num_lags + 1]++;
					if (t + 1 < sched_len && sched[t][i] && sched[t + 1][j])
						exp_cross[pair * num_lags + 2]++;
					if (t + 1 < sched_len && sched[t][j] && sched[t + 1][i])
						exp_cross[pair * num_lags]++;
					pair++;
				end
			end
		end
	endtask

	task automatic wait_idle();
		logic [wb_dat_width-1:0] status;
		status = 32'h1;
		while (status[0])
			wb_read(reg_status, status);
	endtask

	// Starts a window, plays the schedule as 2-cycle pulses away from the idle level.
	task automatic run_window(input logic [window_width-1:0] len, input logic [num_inputs-1:0] idle);
		logic [num_inputs-1:0] prev;
		prev = '0;
		wb_write(reg_cmd, {16'h0, op_start, len});
		repeat (lead_cycles) @(posedge pllclk);
		for (int t = 0; t < sched_len; t++) begin
			@(posedge pllclk);
			line_in <= idle ^ (sched[t] | prev);
			prev = sched[t];
		end
		@(posedge pllclk);
		line_in <= idle;
		wait_idle();
		exp_frames++;
		windows_run++;
	endtask

	task automatic test_reset();
		read_expect(reg_status, 32'h0, "status");
		read_expect(reg_window, 32'h0, "window");
		read_expect(8'h50, 32'h0, "unmapped");
		for (int c = 0; c < num_inputs; c++)
			exp_auto[c] = 0;
		for (int k = 0; k < num_cross; k++)
			exp_cross[k] = 0;
		expect_counts();
		wb_write(reg_window, {16'h0, op_start, 12'd5}); // Would start a window if decoded.
		read_expect(reg_window, 32'h0, "window");
		read_expect(reg_status, 32'h0, "status");
	endtask

	task automatic test_auto();
		clear_sched();
		add_pulses(0, 30, 9, 200);
		add_pulses(1, 31, 13, 130);
		add_pulses(2, 40, 17, 100);
		add_pulses(3, 55, 25, 70);
		compute_expected();
		run_window(window_width'(count_window), '0);
		expect_counts();
		read_expect(reg_status, {16'h0, 8'(exp_frames), 8'h0}, "status");
	endtask

	task automatic test_cross();
		clear_sched();
		add_pulses(0, 100, 20, 5); // Same cycle.
		add_pulses(1, 100, 20, 5);
		add_pulses(0, 600, 20, 7); // Channel 1 one cycle later.
		add_pulses(1, 601, 20, 7);
		add_pulses(1, 1200, 20, 3); // Channel 1 one cycle earlier.
		add_pulses(0, 1201, 20, 3);
		exp_auto = '{15, 15, 0, 0};
		for (int k = 0; k < num_cross; k++)
			exp_cross[k] = 0;
		exp_cross[0] = 3;
		exp_cross[1] = 5;
		exp_cross[2] = 7;
		run_window(window_width'(count_window), '0);
		expect_counts();
	endtask

	task automatic test_invert();
		wb_write(reg_cmd, {16'h0, op_invert, 8'h0, 4'h4});
		repeat (8) @(posedge pllclk);
		line_in <= 4'b0100; // Idle high on channel 2.
		repeat (8) @(posedge pllclk);
		clear_sched();
		add_pulses(2, 50, 150, 9);
		add_pulses(3, 50, 150, 9); // Lines up with channel 2 only when it is inverted.
		compute_expected();
		run_window(window_width'(count_window), 4'b0100);
		expect_counts();
		line_in <= 4'b0000;
		repeat (8) @(posedge pllclk);
		wb_write(reg_cmd, {16'h0, op_invert, 12'h0});
		repeat (8) @(posedge pllclk);
	endtask

	task automatic test_window();
		wb_write(reg_cmd, {16'h0, op_start, 12'd300});
		repeat (50) @(posedge pllclk);
		wb_write(reg_cmd, {16'h0, op_start, 12'd500}); // Lands mid-window.
		wait_idle();
		exp_frames++;
		windows_run++;
		read_expect(reg_window, 32'd300, "window");
		read_expect(reg_status, {16'h0, 8'(exp_frames), 8'h0}, "status");
		checks++;
		if (irq_count != windows_run) begin
			errors++;
			$display("Mismatch irq_count: got 0x%08h, expected 0x%08h", irq_count, windows_run);
		end
		wb_write(reg_cmd, {16'h0, op_clear, 12'h0});
		exp_frames = 0;
		read_expect(reg_status, 32'h0, "status");
	endtask

	task automatic test_random();
		int t;
		clear_sched();
		for (int c = 0; c < num_inputs; c++) begin
			t = 5 + $unsigned($random(seed)) % 8;
			while (t < sched_len - 2) begin
				sched[t][c] = 1'b1;
				t = t + 4 + $unsigned($random(seed)) % 12;
			end
		end
		compute_expected();
		run_window(window_width'(count_window), '0);
		expect_counts();
		read_expect(reg_status, {16'h0, 8'(exp_frames), 8'h0}, "status");
	endtask

	initial begin
		line_in = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		seed = 32'h30cff876;
		wait (rst_n === 1'b1);
		repeat (2) @(posedge pllclk);
		test_reset();
		test_auto();
		test_cross();
		test_invert();
		test_window();
		test_random();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset generator, 40 ns pllclk with an 8-cycle reset.
`timescale 1ns/1ps

module tb_clkgen (
	output logic pllclk,
	output logic rst_n
);

	initial pllclk = 1'b0;

	always #20 pllclk = ~pllclk; // 40 ns period.

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge pllclk);
		rst_n <= 1'b1;
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the correlator testbench with Verilator, run it and check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module corr_tb \
	-f tb.f \
	-o corr_sim

./obj_dir/corr_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== src/coincidence_counter.sv ====
// Per-channel edge counters, one-cycle lag line and saturating pairwise coincidence counters.
`timescale 1ns/1ps

module coincidence_counter import corr_pkg::*; (
	input  logic                             pllclk,
	input  logic                             rst_n,
	input  logic [num_inputs-1:0]            pulse_edge,
	input  logic                             integrating,
	input  logic                             clear,
	output logic [num_inputs*count_width-1:0] auto_count,
	output logic [num_cross*count_width-1:0]  cross_count
);

	logic [num_inputs-1:0] edge_d;

	function automatic logic [count_width-1:0] sat_inc(input logic [count_width-1:0] v);
		return (&v) ? v : v + 1'b1;
	endfunction

	// Delay line for the +1 and -1 lags.
	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			edge_d <= '0;
		end else begin
			edge_d <= pulse_edge;
		end
	end

	// Lag 0 autocorrelation, one counter per channel.
	for (genvar c = 0; c < num_inputs; c++) begin : g_auto
		logic [count_width-1:0] cnt;

		always_ff @(posedge pllclk) begin
			if (!rst_n || clear) begin
				cnt <= '0;
			end else if (integrating && pulse_edge[c]) begin
				cnt <= sat_inc(cnt);
			end
		end

		assign auto_count[c*count_width +: count_width] = cnt;
	end

	// Cross-correlation for every pair i < j.
	for (genvar i = 0; i < num_inputs - 1; i++) begin : g_i
		for (genvar j = i + 1; j < num_inputs; j++) begin : g_j
			localparam int pair = i * (2 * num_inputs - i - 1) / 2 + j - i - 1;
			logic [num_lags-1:0] hit;

			assign hit[0] = edge_d[j] & pulse_edge[i]; // j one cycle before i.
			assign hit[1] = pulse_edge[i] & pulse_edge[j];
			assign hit[2] = edge_d[i] & pulse_edge[j]; // j one cycle after i.

			for (genvar l = 0; l < num_lags; l++) begin : g_lag
				logic [count_width-1:0] cnt;

				always_ff @(posedge pllclk) begin
					if (!rst_n || clear) begin
						cnt <= '0;
					end else if (integrating && hit[l]) begin
						cnt <= sat_inc(cnt);
					end
				end

				assign cross_count[(pair*num_lags + l)*count_width +: count_width] = cnt;
			end
		end
	end

endmodule

// ==== src/corr_pkg.sv ====
// Correlator sizes, Wishbone register map, command opcodes and the command word union.
package corr_pkg;

	// Channel and lag geometry.
	localparam int num_inputs = 4;
	localparam int num_pairs = num_inputs * (num_inputs - 1) / 2; // (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	localparam int num_lags = 3; // Index 0 is lag -1, 1 is lag 0, 2 is lag +1.
	localparam int num_cross = num_pairs * num_lags;

	localparam int count_width = 16; // Counters saturate at all ones.
	localparam int window_width = 12;
	localparam int frame_width = 8;
	localparam int op_width = 4;
	localparam int cmd_width = 16;

	localparam int wb_adr_width = 8;
	localparam int wb_dat_width = 32;

	// Register map.
	localparam logic [wb_adr_width-1:0] reg_cmd = 8'h00; // Write only.
	localparam logic [wb_adr_width-1:0] reg_status = 8'h01;
	localparam logic [wb_adr_width-1:0] reg_window = 8'h02;
	localparam logic [wb_adr_width-1:0] reg_auto_base = 8'h10;
	localparam logic [wb_adr_width-1:0] reg_cross_base = 8'h20; // Plus pair * 3 plus lag index.

	// Opcodes in the top nibble of the command word.
	localparam logic [op_width-1:0] op_start = 4'd1;
	localparam logic [op_width-1:0] op_invert = 4'd2;
	localparam logic [op_width-1:0] op_clear = 4'd3;

	// One command word, read as a window length or as an inversion mask.
	typedef union packed {
		struct packed {
			logic [op_width-1:0] opcode;
			logic [window_width-1:0] length;
		} win;
		struct packed {
			logic [op_width-1:0] opcode;
			logic [7:0] reserved;
			logic [num_inputs-1:0] invert_mask;
		} mask;
	} cmd_word_u;

endpackage

// ==== src/corr_top.sv ====
// Top level of the four-input intensity correlator with its Wishbone slave.
`timescale 1ns/1ps

module corr_top import corr_pkg::*; (
	input  logic                    pllclk,
	input  logic                    rst_n,
	input  logic [num_inputs-1:0]   line_in,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [wb_adr_width-1:0] wb_adr,
	input  logic [wb_dat_width-1:0] wb_dat_i,
	output logic [wb_dat_width-1:0] wb_dat_o,
	output logic                    wb_ack,
	output logic                    irq
);

	logic [num_inputs-1:0] pulse_edge;
	logic [num_inputs-1:0] invert_mask;
	logic integrating;
	logic clear;
	logic snapshot;
	logic [frame_width-1:0] frame_count;
	logic [window_width-1:0] window_len;
	logic cmd_valid;
	cmd_word_u cmd_word;
	logic [num_inputs*count_width-1:0] auto_count;
	logic [num_cross*count_width-1:0] cross_count;

	pulse_sampler u_sampler (
		.pllclk      (pllclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.pulse_edge  (pulse_edge)
	);

	coincidence_counter u_counter (
		.pllclk      (pllclk),
		.rst_n       (rst_n),
		.pulse_edge  (pulse_edge),
		.integrating (integrating),
		.clear       (clear),
		.auto_count  (auto_count),
		.cross_count (cross_count)
	);

	integration_ctrl u_ctrl (
		.pllclk      (pllclk),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_word    (cmd_word),
		.invert_mask (invert_mask),
		.integrating (integrating),
		.clear       (clear),
		.snapshot    (snapshot),
		.irq         (irq),
		.frame_count (frame_count),
		.window_len  (window_len)
	);

	corr_wb_regs u_regs (
		.pllclk      (pllclk),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.auto_count  (auto_count),
		.cross_count (cross_count),
		.snapshot    (snapshot),
		.integrating (integrating),
		.frame_count (frame_count),
		.window_len  (window_len),
		.cmd_valid   (cmd_valid),
		.cmd_word    (cmd_word)
	);

endmodule

// ==== src/corr_wb_regs.sv ====
// Wishbone classic slave with command register, snapshot readout bank and read mux.
`timescale 1ns/1ps

module corr_wb_regs import corr_pkg::*; (
	input  logic                             pllclk,
	input  logic                             rst_n,
	input  logic                             wb_cyc,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic [wb_adr_width-1:0]          wb_adr,
	input  logic [wb_dat_width-1:0]          wb_dat_i,
	output logic [wb_dat_width-1:0]          wb_dat_o,
	output logic                             wb_ack,
	input  logic [num_inputs*count_width-1:0] auto_count,
	input  logic [num_cross*count_width-1:0]  cross_count,
	input  logic                             snapshot,
	input  logic                             integrating,
	input  logic [frame_width-1:0]           frame_count,
	input  logic [window_width-1:0]          window_len,
	output logic                             cmd_valid,
	output cmd_word_u                        cmd_word
);

	logic access;
	logic cmd_write;
	logic [num_inputs*count_width-1:0] auto_bank;
	logic [num_cross*count_width-1:0] cross_bank;
	logic [wb_dat_width-1:0] rd_next;

	// New cycle seen; the ack cycle itself never starts another.
	assign access = wb_cyc & wb_stb & ~wb_ack;
	assign cmd_write = access & wb_we & (wb_adr == reg_cmd);

	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			cmd_valid <= 1'b0;
			wb_dat_o <= '0;
		end else begin
			wb_ack <= access;
			cmd_valid <= cmd_write;
			if (access)
				wb_dat_o <= rd_next;
		end
	end

	always_ff @(posedge pllclk) begin
		if (cmd_write)
			cmd_word <= cmd_word_u'(wb_dat_i[cmd_width-1:0]);
	end

	// Frozen copy of the counters at the end of each window.
	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			auto_bank <= '0;
			cross_bank <= '0;
		end else if (snapshot) begin
			auto_bank <= auto_count;
			cross_bank <= cross_count;
		end
	end

	always_comb begin
		logic [wb_adr_width-1:0] ofs;
		rd_next = '0;
		ofs = '0;
		if (wb_adr == reg_status) begin
			rd_next[0] = integrating;
			rd_next[15:8] = frame_count;
		end else if (wb_adr == reg_window) begin
			rd_next[window_width-1:0] = window_len;
		end else if (wb_adr >= reg_auto_base && wb_adr < reg_auto_base + num_inputs) begin
			ofs = wb_adr - reg_auto_base;
			rd_next[count_width-1:0] = auto_bank[ofs*count_width +: count_width];
		end else if (wb_adr >= reg_cross_base && wb_adr < reg_cross_base + num_cross) begin
			ofs = wb_adr - reg_cross_base;
			rd_next[count_width-1:0] = cross_bank[ofs*count_width +: count_width];
		end
	end

endmodule

// ==== src/integration_ctrl.sv ====
// Command decode, integration window countdown, clear and snapshot strobes, frame counter.
`timescale 1ns/1ps

module integration_ctrl import corr_pkg::*; (
	input  logic                    pllclk,
	input  logic                    rst_n,
	input  logic                    cmd_valid,
	input  cmd_word_u               cmd_word,
	output logic [num_inputs-1:0]   invert_mask,
	output logic                    integrating,
	output logic                    clear,
	output logic                    snapshot,
	output logic                    irq,
	output logic [frame_width-1:0]  frame_count,
	output logic [window_width-1:0] window_len
);

	logic [op_width-1:0] opcode;
	logic [window_width-1:0] remaining;
	logic armed; // Clear cycle that precedes a window.
	logic start_ok;

	assign opcode = cmd_word.win.opcode;
	assign start_ok = cmd_valid && opcode == op_start && !integrating && !clear &&
		cmd_word.win.length != '0;

	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			invert_mask <= '0;
			integrating <= 1'b0;
			clear <= 1'b0;
			snapshot <= 1'b0;
			irq <= 1'b0;
			armed <= 1'b0;
			frame_count <= '0;
			window_len <= '0;
		end else begin
			clear <= 1'b0;
			snapshot <= 1'b0;
			irq <= 1'b0;
			armed <= 1'b0;
			if (start_ok) begin
				clear <= 1'b1;
				armed <= 1'b1;
				window_len <= cmd_word.win.length;
			end
			if (armed) begin
				integrating <= 1'b1;
			end else if (integrating && remaining == 1) begin
				integrating <= 1'b0; // Last counted cycle.
				snapshot <= 1'b1;
				irq <= 1'b1;
				frame_count <= frame_count + 1'b1;
			end
			if (cmd_valid && opcode == op_invert)
				invert_mask <= cmd_word.mask.invert_mask;
			if (cmd_valid && opcode == op_clear) begin
				clear <= 1'b1;
				frame_count <= '0;
			end
		end
	end

	// Cycles left in the window.
	always_ff @(posedge pllclk) begin
		if (start_ok)
			remaining <= cmd_word.win.length;
		else if (integrating)
			remaining <= remaining - 1'b1;
	end

endmodule

// ==== src/pulse_sampler.sv ====
// Pulse input synchroniser with per-channel inversion and rising-edge detection.
`timescale 1ns/1ps

module pulse_sampler import corr_pkg::*; (
	input  logic                  pllclk,
	input  logic                  rst_n,
	input  logic [num_inputs-1:0] line_in,
	input  logic [num_inputs-1:0] invert_mask,
	output logic [num_inputs-1:0] pulse_edge
);

	logic [num_inputs-1:0] sync_q1;
	logic [num_inputs-1:0] sync_q2;
	logic [num_inputs-1:0] level;
	logic [num_inputs-1:0] level_q;

	// Two flops against metastability on the asynchronous lines.
	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= line_in;
			sync_q2 <= sync_q1;
		end
	end

	assign level = sync_q2 ^ invert_mask; // Conditioned level.

	// Same latency on every channel, so relative timing is kept.
	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			level_q <= '0;
			pulse_edge <= '0;
		end else begin
			level_q <= level;
			pulse_edge <= level & ~level_q;
		end
	end

endmodule

// ==== tb.f ====
src/corr_pkg.sv
src/pulse_sampler.sv
src/coincidence_counter.sv
src/integration_ctrl.sv
src/corr_wb_regs.sv
src/corr_top.sv
dv/tb_clkgen.sv
dv/corr_sva.sv
dv/corr_tb.sv
